/* verilog/scaler_ctrl_pkg.sv */
package scaler_ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths

	typedef logic [11:0] coord_t;

	// Bit 12 set means a direct size rather than a ratio
	typedef logic [12:0] ar_t;

	typedef logic [15:0] io_word_t;
	typedef logic [7:0]  cmd_t;

	////////////////////////////////////////////////////////////////////////////
	// Bundles

	typedef struct packed {
		logic     io_clk;
		logic     uio;
		io_word_t din;
	} host_bus_t;

	typedef struct packed {
		coord_t width;
		coord_t height;
		coord_t vset;
		coord_t hset;
		logic   freescale;
		ar_t    arc1x;
		ar_t    arc1y;
		ar_t    arc2x;
		ar_t    arc2y;
	} scale_cfg_t;

	typedef struct packed {
		coord_t hmin;
		coord_t hmax;
		coord_t vmin;
		coord_t vmax;
	} window_t;

	////////////////////////////////////////////////////////////////////////////
	// Host command codes

	localparam cmd_t CMD_CFG     = 8'h01;
	localparam cmd_t CMD_TIMING  = 8'h20;
	localparam cmd_t CMD_LED     = 8'h25;
	localparam cmd_t CMD_VOL     = 8'h26;
	localparam cmd_t CMD_VSET    = 8'h27;
	localparam cmd_t CMD_HSET    = 8'h37;
	localparam cmd_t CMD_ARC     = 8'h3A;
	localparam cmd_t CMD_READ_AR = 8'h40;

	localparam coord_t     DEF_WIDTH   = 12'd1920;
	localparam coord_t     DEF_HEIGHT  = 12'd1080;
	localparam logic [4:0] DEF_VOL_ATT = 5'b11111;

endpackage

/* verilog/ar_muldiv.sv */
module ar_muldiv (
	input  logic                    clk_sys,
	input  logic                    resetd,
	input  logic                    i_start,
	input  scaler_ctrl_pkg::coord_t i_mul1,
	input  scaler_ctrl_pkg::coord_t i_mul2,
	input  scaler_ctrl_pkg::coord_t i_div,
	output logic                    o_busy,
	output scaler_ctrl_pkg::coord_t o_result
);

	scaler_ctrl_pkg::coord_t op_a;
	scaler_ctrl_pkg::coord_t op_b;
	scaler_ctrl_pkg::coord_t div_q;
	logic [4:0]              step;
	logic [23:0]             quo;
	logic [11:0]             rem;
	logic [12:0]             rem_shift;
	logic                    rem_ge;

	assign rem_shift = {rem, quo[23]};
	assign rem_ge    = rem_shift >= {1'b0, div_q};

	// Step 0 multiplies, steps 1 to 24 divide
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			step   <= '0;
		end else if (i_start) begin
			o_busy <= 1'b1;
			step   <= '0;
		end else if (o_busy) begin
			step <= step + 5'd1;
			if (step == 5'd24) begin
				o_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			op_a  <= i_mul1;
			op_b  <= i_mul2;
			div_q <= i_div;
		end else if (o_busy) begin
			if (step == 5'd0) begin
				quo <= op_a * op_b;
				rem <= '0;
			end else begin
				quo <= {quo[22:0], rem_ge};
				rem <= rem_ge ? 12'(rem_shift - {1'b0, div_q}) : rem_shift[11:0];
			end
		end
	end

	// Zero divisor leaves every quotient bit set
	assign o_result = quo[11:0];

endmodule

/* verilog/hps_cmd_decoder.sv */
module hps_cmd_decoder (
	input  logic                        clk_sys,
	input  logic                        resetd,
	input  scaler_ctrl_pkg::host_bus_t  i_host,
	input  scaler_ctrl_pkg::coord_t     i_arx,
	input  scaler_ctrl_pkg::coord_t     i_ary,
	input  logic                        i_arxy,
	output logic                        o_io_ack,
	output scaler_ctrl_pkg::io_word_t   o_io_dout,
	output scaler_ctrl_pkg::scale_cfg_t o_cfg,
	output logic                        o_csync_en,
	output logic [7:0]                  o_led,
	output logic [4:0]                  o_vol_att
);

	scaler_ctrl_pkg::host_bus_t  host_s1;
	scaler_ctrl_pkg::host_bus_t  host_s2;
	scaler_ctrl_pkg::io_word_t   din;
	scaler_ctrl_pkg::cmd_t       cmd;
	scaler_ctrl_pkg::scale_cfg_t cfg;
	logic                        io_strobe;
	logic                        has_cmd;
	logic [7:0]                  word_cnt;
	logic [7:0]                  led_overtake;
	logic [7:0]                  led_state;

	////////////////////////////////////////////////////////////////////////////
	// Host port

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			host_s1  <= '0;
			host_s2  <= '0;
			o_io_ack <= 1'b0;
		end else begin
			host_s1  <= i_host;
			host_s2  <= host_s1;
			// Ack trails the synchronized clock by one cycle
			o_io_ack <= host_s2.io_clk;
		end
	end

	assign io_strobe = host_s2.io_clk & ~o_io_ack;
	assign din       = host_s2.din;

	////////////////////////////////////////////////////////////////////////////
	// Command and data words

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd      <= 1'b0;
			cmd          <= '0;
			word_cnt     <= '0;
			o_io_dout    <= '0;
			o_csync_en   <= 1'b0;
			led_overtake <= '0;
			led_state    <= '0;
			o_vol_att    <= scaler_ctrl_pkg::DEF_VOL_ATT;
			cfg          <= '0;
			cfg.width    <= scaler_ctrl_pkg::DEF_WIDTH;
			cfg.height   <= scaler_ctrl_pkg::DEF_HEIGHT;
		end else if (!host_s2.uio) begin
			has_cmd   <= 1'b0;
			cmd       <= '0;
			o_io_dout <= '0;
		end else if (io_strobe) begin
			o_io_dout <= '0;
			if (!has_cmd) begin
				has_cmd  <= 1'b1;
				cmd      <= din[7:0];
				word_cnt <= '0;
				if (din[7:0] == scaler_ctrl_pkg::CMD_TIMING) begin
					o_io_dout <= 16'd3;
				end
			end else begin
				word_cnt <= word_cnt + 8'd1;
				case (cmd)
					scaler_ctrl_pkg::CMD_CFG: begin
						o_csync_en <= din[3];
					end
					scaler_ctrl_pkg::CMD_TIMING: begin
						// Only the active size is kept
						if (word_cnt == 8'd0) begin
							cfg.width <= din[11:0];
						end
						if (word_cnt == 8'd4) begin
							cfg.height <= din[11:0];
						end
					end
					scaler_ctrl_pkg::CMD_LED: begin
						led_overtake <= din[15:8];
						led_state    <= din[7:0];
					end
					scaler_ctrl_pkg::CMD_VOL: begin
						o_vol_att <= din[4:0];
					end
					scaler_ctrl_pkg::CMD_VSET: begin
						cfg.vset <= din[11:0];
					end
					scaler_ctrl_pkg::CMD_HSET: begin
						cfg.freescale <= din[15];
						cfg.hset      <= din[11:0];
					end
					scaler_ctrl_pkg::CMD_ARC: begin
						case (word_cnt)
							8'd0: cfg.arc1x <= din[12:0];
							8'd1: cfg.arc1y <= din[12:0];
							8'd2: cfg.arc2x <= din[12:0];
							8'd3: cfg.arc2y <= din[12:0];
							default: ;
						endcase
					end
					scaler_ctrl_pkg::CMD_READ_AR: begin
						if (word_cnt == 8'd0) begin
							o_io_dout <= {3'b000, i_arxy, i_arx};
						end
						if (word_cnt == 8'd1) begin
							o_io_dout <= {3'b000, i_arxy, i_ary};
						end
					end
					default: ;
				endcase
			end
		end
	end

	assign o_cfg = cfg;
	assign o_led = led_overtake & led_state;

endmodule

/* verilog/video_window_calc.sv */
module video_window_calc (
	input  logic                        clk_sys,
	input  logic                        resetd,
	input  scaler_ctrl_pkg::scale_cfg_t i_cfg,
	input  scaler_ctrl_pkg::ar_t        i_video_arx,
	input  scaler_ctrl_pkg::ar_t        i_video_ary,
	output scaler_ctrl_pkg::window_t    o_window,
	output scaler_ctrl_pkg::coord_t     o_arx,
	output scaler_ctrl_pkg::coord_t     o_ary,
	output logic                        o_arxy
);

	typedef enum logic [2:0] {
		S_DECIDE,
		S_MUL_W,
		S_WAIT_W,
		S_MUL_H,
		S_WAIT_H,
		S_CLAMP,
		S_CENTER
	} state_t;

	state_t                  state;
	scaler_ctrl_pkg::coord_t out_w;
	scaler_ctrl_pkg::coord_t out_h;
	scaler_ctrl_pkg::coord_t wcalc;
	scaler_ctrl_pkg::coord_t hcalc;
	scaler_ctrl_pkg::coord_t video_w;
	scaler_ctrl_pkg::coord_t video_h;
	scaler_ctrl_pkg::coord_t h_off;
	scaler_ctrl_pkg::coord_t v_off;
	scaler_ctrl_pkg::coord_t md_mul1;
	scaler_ctrl_pkg::coord_t md_mul2;
	scaler_ctrl_pkg::coord_t md_div;
	scaler_ctrl_pkg::coord_t md_res;
	logic                    md_start;
	logic                    md_busy;

	ar_muldiv u_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	////////////////////////////////////////////////////////////////////////////
	// Output size limits and aspect source

	always_ff @(posedge clk_sys) begin
		out_w <= (i_cfg.hset != '0 && i_cfg.hset < i_cfg.width) ? i_cfg.hset : i_cfg.width;
		out_h <= (i_cfg.vset != '0 && i_cfg.vset < i_cfg.height) ? i_cfg.vset : i_cfg.height;

		if (i_video_ary != '0) begin
			o_arx  <= i_video_arx[11:0];
			o_ary  <= i_video_ary[11:0];
			o_arxy <= i_video_arx[12] | i_video_ary[12];
		end else if (i_video_arx == 13'd1) begin
			o_arx  <= i_cfg.arc1x[11:0];
			o_ary  <= i_cfg.arc1y[11:0];
			o_arxy <= i_cfg.arc1x[12] | i_cfg.arc1y[12];
		end else if (i_video_arx == 13'd2) begin
			o_arx  <= i_cfg.arc2x[11:0];
			o_ary  <= i_cfg.arc2y[11:0];
			o_arxy <= i_cfg.arc2x[12] | i_cfg.arc2y[12];
		end else begin
			o_arx  <= '0;
			o_ary  <= '0;
			o_arxy <= 1'b0;
		end
	end

	assign h_off = 12'(i_cfg.width - video_w) >> 1;
	assign v_off = 12'(i_cfg.height - video_h) >> 1;

	////////////////////////////////////////////////////////////////////////////
	// Window FSM, runs continuously

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state         <= S_DECIDE;
			md_start      <= 1'b0;
			o_window.hmin <= '0;
			o_window.hmax <= scaler_ctrl_pkg::DEF_WIDTH - 12'd1;
			o_window.vmin <= '0;
			o_window.vmax <= scaler_ctrl_pkg::DEF_HEIGHT - 12'd1;
		end else begin
			md_start <= 1'b0;
			case (state)
				S_DECIDE: begin
					if (i_cfg.freescale || o_arx == '0 || o_ary == '0) begin
						wcalc <= out_w;
						hcalc <= out_h;
						state <= S_CLAMP;
					end else if (o_arxy) begin
						wcalc <= o_arx;
						hcalc <= o_ary;
						state <= S_CLAMP;
					end else begin
						state <= S_MUL_W;
					end
				end
				S_MUL_W: begin
					md_mul1  <= out_h;
					md_mul2  <= o_arx;
					md_div   <= o_ary;
					md_start <= 1'b1;
					state    <= S_WAIT_W;
				end
				S_WAIT_W: begin
					wcalc <= md_res;
					if (!(md_start || md_busy)) begin
						state <= S_MUL_H;
					end
				end
				S_MUL_H: begin
					md_mul1  <= out_w;
					md_mul2  <= o_ary;
					md_div   <= o_arx;
					md_start <= 1'b1;
					state    <= S_WAIT_H;
				end
				S_WAIT_H: begin
					hcalc <= md_res;
					if (!(md_start || md_busy)) begin
						state <= S_CLAMP;
					end
				end
				S_CLAMP: begin
					video_w <= (wcalc > out_w) ? out_w : wcalc;
					video_h <= (hcalc > out_h) ? out_h : hcalc;
					state   <= S_CENTER;
				end
				S_CENTER: begin
					o_window.hmin <= h_off;
					o_window.hmax <= h_off + video_w - 12'd1;
					o_window.vmin <= v_off;
					o_window.vmax <= v_off + video_h - 12'd1;
					state         <= S_DECIDE;
				end
				default: state <= S_DECIDE;
			endcase
		end
	end

endmodule

/* verilog/sync_polarity_fix.sv */
module sync_polarity_fix #(
	parameter int CNT_W = 16
) (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic             sync_s1;
	logic             sync_s2;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] high_len;
	logic [CNT_W-1:0] low_len;
	logic             invert;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_s1  <= 1'b0;
			sync_s2  <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			invert   <= 1'b0;
		end else begin
			sync_s1 <= i_sync;
			sync_s2 <= sync_s1;
			if (sync_s1 != sync_s2) begin
				// Phase now ending is the one held in sync_s2
				cnt <= '0;
				if (sync_s2) begin
					high_len <= cnt;
				end else begin
					low_len <= cnt;
				end
			end else if (~&cnt) begin
				cnt <= cnt + 1'b1;
			end
			invert <= high_len > low_len;
		end
	end

	assign o_sync = sync_s2 ^ invert;

endmodule

/* verilog/csync_gen.sv */
module csync_gen #(
	parameter int CNT_W = 16
) (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hs,
	input  logic i_vs,
	output logic o_csync
);

	logic             hs_d;
	logic             csync_hs;
	logic             csync_vs;
	logic [CNT_W-1:0] h_cnt;
	logic [CNT_W-1:0] line_len;
	logic [CNT_W-1:0] hs_len;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_d     <= 1'b0;
			csync_hs <= 1'b0;
			csync_vs <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			hs_d     <= i_hs;
			csync_vs <= i_vs;

			// Line length minus pulse, and pulse length
			if (hs_d != i_hs) begin
				h_cnt <= '0;
				if (i_hs) begin
					line_len <= h_cnt - hs_len;
				end else begin
					hs_len <= h_cnt;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end

			// In vsync the pulse moves to the end of the line
			if (!i_vs) begin
				csync_hs <= i_hs;
			end else if (!hs_d && i_hs) begin
				csync_hs <= 1'b0;
			end else if (h_cnt == line_len) begin
				csync_hs <= 1'b1;
			end
		end
	end

	assign o_csync = csync_hs ^ csync_vs;

endmodule

/* verilog/scaler_ctrl_top.sv */
module scaler_ctrl_top #(
	parameter int SYNC_CNT_W = 16
) (
	input  logic                       clk_sys,
	input  logic                       resetd,
	input  scaler_ctrl_pkg::host_bus_t i_host,
	input  scaler_ctrl_pkg::ar_t       i_video_arx,
	input  scaler_ctrl_pkg::ar_t       i_video_ary,
	input  logic                       i_vid_hs,
	input  logic                       i_vid_vs,
	output logic                       o_io_ack,
	output scaler_ctrl_pkg::io_word_t  o_io_dout,
	output logic [7:0]                 o_led,
	output logic [4:0]                 o_vol_att,
	output scaler_ctrl_pkg::window_t   o_window,
	output logic                       o_vga_hs,
	output logic                       o_vga_vs,
	output logic                       o_csync
);

	scaler_ctrl_pkg::scale_cfg_t cfg;
	scaler_ctrl_pkg::coord_t     arx;
	scaler_ctrl_pkg::coord_t     ary;
	logic                        arxy;
	logic                        csync_en;
	logic                        hs_fix;
	logic                        vs_fix;

	hps_cmd_decoder u_decoder (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_host     (i_host),
		.i_arx      (arx),
		.i_ary      (ary),
		.i_arxy     (arxy),
		.o_io_ack   (o_io_ack),
		.o_io_dout  (o_io_dout),
		.o_cfg      (cfg),
		.o_csync_en (csync_en),
		.o_led      (o_led),
		.o_vol_att  (o_vol_att)
	);

	video_window_calc u_window (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_cfg       (cfg),
		.i_video_arx (i_video_arx),
		.i_video_ary (i_video_ary),
		.o_window    (o_window),
		.o_arx       (arx),
		.o_ary       (ary),
		.o_arxy      (arxy)
	);

	////////////////////////////////////////////////////////////////////////////
	// Analog sync path

	sync_polarity_fix #(.CNT_W(SYNC_CNT_W)) u_hs_fix (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vid_hs),
		.o_sync  (hs_fix)
	);

	sync_polarity_fix #(.CNT_W(SYNC_CNT_W)) u_vs_fix (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vid_vs),
		.o_sync  (vs_fix)
	);

	csync_gen #(.CNT_W(SYNC_CNT_W)) u_csync (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_hs    (hs_fix),
		.i_vs    (vs_fix),
		.o_csync (o_csync)
	);

	assign o_vga_hs = csync_en ? o_csync : hs_fix;
	assign o_vga_vs = vs_fix;

endmodule

/* sim/tb_checker.sv */
module tb_checker (
	input  logic                        clk_sys,
	input  logic                        resetd,
	input  logic                        i_chk_reset,
	input  logic                        i_chk_regs,
	input  logic                        i_chk_window,
	input  logic                        i_chk_rd_timing,
	input  logic                        i_chk_rd_arx,
	input  logic                        i_chk_rd_ary,
	input  scaler_ctrl_pkg::scale_cfg_t i_cfg,
	input  scaler_ctrl_pkg::io_word_t   i_led_word,
	input  scaler_ctrl_pkg::io_word_t   i_vol_word,
	input  scaler_ctrl_pkg::ar_t        i_video_arx,
	input  scaler_ctrl_pkg::ar_t        i_video_ary,
	input  logic                        i_vid_hs,
	input  logic                        i_vid_vs,
	input  logic                        i_pol_en,
	input  int                          i_pol_len,
	input  logic                        i_cs_en,
	input  logic                        i_hs_inv,
	input  scaler_ctrl_pkg::io_word_t   i_io_dout,
	input  logic [7:0]                  i_led,
	input  logic [4:0]                  i_vol_att,
	input  scaler_ctrl_pkg::window_t    i_window,
	input  logic                        i_vga_hs,
	input  logic                        i_vga_vs,
	input  logic                        i_csync,
	output int                          o_val_errs,
	output int                          o_other_errs
);

	typedef struct packed {
		logic                    xy;
		scaler_ctrl_pkg::coord_t x;
		scaler_ctrl_pkg::coord_t y;
	} aspect_t;

	aspect_t    asp;
	logic [2:0] hs_hist;
	logic [1:0] vs_hist;
	logic       vga_hs_d;
	logic       pol_en_d;
	int         high_run;
	int         pol_pulses;

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic aspect_t ref_aspect(input scaler_ctrl_pkg::scale_cfg_t cfg,
			input scaler_ctrl_pkg::ar_t vx, input scaler_ctrl_pkg::ar_t vy);
		aspect_t a;
		a = '0;
		if (vy != '0) begin
			a.x  = vx[11:0];
			a.y  = vy[11:0];
			a.xy = vx[12] | vy[12];
		end else if (vx == 13'd1) begin
			a.x  = cfg.arc1x[11:0];
			a.y  = cfg.arc1y[11:0];
			a.xy = cfg.arc1x[12] | cfg.arc1y[12];
		end else if (vx == 13'd2) begin
			a.x  = cfg.arc2x[11:0];
			a.y  = cfg.arc2y[11:0];
			a.xy = cfg.arc2x[12] | cfg.arc2y[12];
		end
		return a;
	endfunction

	function automatic scaler_ctrl_pkg::window_t ref_window(
			input scaler_ctrl_pkg::scale_cfg_t cfg, input aspect_t a);
		scaler_ctrl_pkg::coord_t  hw;
		scaler_ctrl_pkg::coord_t  hh;
		scaler_ctrl_pkg::coord_t  w;
		scaler_ctrl_pkg::coord_t  h;
		scaler_ctrl_pkg::coord_t  diff;
		logic [23:0]              prod;
		logic [23:0]              quo;
		scaler_ctrl_pkg::window_t win;
		hw = (cfg.hset != '0 && cfg.hset < cfg.width) ? cfg.hset : cfg.width;
		hh = (cfg.vset != '0 && cfg.vset < cfg.height) ? cfg.vset : cfg.height;
		if (cfg.freescale || a.x == '0 || a.y == '0) begin
			w = hw;
			h = hh;
		end else if (a.xy) begin
			w = a.x;
			h = a.y;
		end else begin
			prod = {12'd0, hh} * {12'd0, a.x};
			quo  = prod / {12'd0, a.y};
			w    = quo[11:0];
			prod = {12'd0, hw} * {12'd0, a.y};
			quo  = prod / {12'd0, a.x};
			h    = quo[11:0];
		end
		if (w > hw) begin
			w = hw;
		end
		if (h > hh) begin
			h = hh;
		end
		diff     = cfg.width - w;
		win.hmin = diff >> 1;
		win.hmax = win.hmin + w - 12'd1;
		diff     = cfg.height - h;
		win.vmin = diff >> 1;
		win.vmax = win.vmin + h - 12'd1;
		return win;
	endfunction

	assign asp = ref_aspect(i_cfg, i_video_arx, i_video_ary);

	task automatic compare(input string name, input logic [47:0] exp, input logic [47:0] act);
		if (exp !== act) begin
			$display("Fail %s expected %0h actual %0h", name, exp, act);
			o_val_errs++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sampling mid-cycle, away from both clock edges

	always @(negedge clk_sys) begin
		if (resetd) begin
			o_val_errs   = 0;
			o_other_errs = 0;
			hs_hist      = '0;
			vs_hist      = '0;
			vga_hs_d     = 1'b0;
			pol_en_d     = 1'b0;
			high_run     = 0;
			pol_pulses   = 0;
		end else begin
			if (i_chk_reset) begin
				compare("reset led", 48'(0), 48'(i_led));
				compare("reset vol_att", 48'(5'h1f), 48'(i_vol_att));
				compare("reset io_dout", 48'(0), 48'(i_io_dout));
				compare("reset window", {12'd0, scaler_ctrl_pkg::DEF_WIDTH - 12'd1,
					12'd0, scaler_ctrl_pkg::DEF_HEIGHT - 12'd1}, i_window);
			end
			if (i_chk_regs) begin
				compare("led", 48'(i_led_word[15:8] & i_led_word[7:0]), 48'(i_led));
				compare("vol_att", 48'(i_vol_word[4:0]), 48'(i_vol_att));
			end
			if (i_chk_window) begin
				compare("window", ref_window(i_cfg, asp), i_window);
			end
			if (i_chk_rd_timing) begin
				compare("timing readback", 48'(3), 48'(i_io_dout));
			end
			if (i_chk_rd_arx) begin
				compare("aspect x readback", 48'({3'b000, asp.xy, asp.x}), 48'(i_io_dout));
			end
			if (i_chk_rd_ary) begin
				compare("aspect y readback", 48'({3'b000, asp.xy, asp.y}), 48'(i_io_dout));
			end

			// Pulse ends on the first low sample
			if (i_pol_en && vga_hs_d && !i_vga_hs) begin
				compare("hsync high length", 48'(i_pol_len), 48'(high_run));
				pol_pulses++;
			end
			if (pol_en_d && !i_pol_en && pol_pulses == 0) begin
				$display("No hsync pulse was seen on vga_hs during the polarity test");
				o_other_errs++;
			end

			// Csync trails the input hsync by three samples
			if (i_cs_en) begin
				compare("vga_hs follows csync", 48'(i_csync), 48'(i_vga_hs));
				compare("csync from hsync", 48'(hs_hist[2] ^ i_hs_inv), 48'(i_csync));
			end

			// Short-high vsync keeps its polarity, two samples late
			compare("vga_vs from vsync", 48'(vs_hist[1]), 48'(i_vga_vs));

			high_run = i_vga_hs ? high_run + 1 : 0;
			vga_hs_d = i_vga_hs;
			pol_en_d = i_pol_en;
			hs_hist  = {hs_hist[1:0], i_vid_hs};
			vs_hist  = {vs_hist[0], i_vid_vs};
		end
	end

endmodule

/* sim/tb_scaler_ctrl.sv */
module tb_clk_gen #(
	parameter int PERIOD = 40
) (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
		forever begin
			#(PERIOD / 2);
			o_clk = ~o_clk;
		end
	end

endmodule

module tb_scaler_ctrl;

	localparam int N_WIN     = 12;
	localparam int WIN_WAIT  = 160;
	localparam int HS_LOW    = 12;
	localparam int HS_HIGH   = 88;
	localparam int HS_PERIOD = HS_LOW + HS_HIGH;
	localparam int VS_LEN    = 2 * HS_PERIOD;

	// One window round counts as six steps
	localparam int N_STEPS     = N_WIN * 6 + 16;
	localparam int CYCLE_LIMIT = 200 * N_STEPS + 2000;

	localparam int CHK_RESET     = 0;
	localparam int CHK_REGS      = 1;
	localparam int CHK_WINDOW    = 2;
	localparam int CHK_RD_TIMING = 3;
	localparam int CHK_RD_ARX    = 4;
	localparam int CHK_RD_ARY    = 5;

	logic                        clk_sys;
	logic                        resetd;
	scaler_ctrl_pkg::host_bus_t  host;
	scaler_ctrl_pkg::ar_t        video_arx;
	scaler_ctrl_pkg::ar_t        video_ary;
	logic                        vid_hs;
	logic                        vid_vs;
	logic                        io_ack;
	scaler_ctrl_pkg::io_word_t   io_dout;
	logic [7:0]                  led;
	logic [4:0]                  vol_att;
	scaler_ctrl_pkg::window_t    window;
	logic                        vga_hs;
	logic                        vga_vs;
	logic                        csync;
	logic [5:0]                  chk_req;
	scaler_ctrl_pkg::scale_cfg_t stim_cfg;
	scaler_ctrl_pkg::io_word_t   led_word;
	scaler_ctrl_pkg::io_word_t   vol_word;
	logic                        pol_en;
	logic                        cs_en;
	logic [31:0]                 lfsr;
	int                          cycle_cnt;
	int                          val_errs;
	int                          other_errs;

	tb_clk_gen #(.PERIOD(40)) u_clk (
		.o_clk (clk_sys)
	);

	scaler_ctrl_top #(.SYNC_CNT_W(16)) UUT (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_host      (host),
		.i_video_arx (video_arx),
		.i_video_ary (video_ary),
		.i_vid_hs    (vid_hs),
		.i_vid_vs    (vid_vs),
		.o_io_ack    (io_ack),
		.o_io_dout   (io_dout),
		.o_led       (led),
		.o_vol_att   (vol_att),
		.o_window    (window),
		.o_vga_hs    (vga_hs),
		.o_vga_vs    (vga_vs),
		.o_csync     (csync)
	);

	tb_checker u_check (
		.clk_sys         (clk_sys),
		.resetd          (resetd),
		.i_chk_reset     (chk_req[CHK_RESET]),
		.i_chk_regs      (chk_req[CHK_REGS]),
		.i_chk_window    (chk_req[CHK_WINDOW]),
		.i_chk_rd_timing (chk_req[CHK_RD_TIMING]),
		.i_chk_rd_arx    (chk_req[CHK_RD_ARX]),
		.i_chk_rd_ary    (chk_req[CHK_RD_ARY]),
		.i_cfg           (stim_cfg),
		.i_led_word      (led_word),
		.i_vol_word      (vol_word),
		.i_video_arx     (video_arx),
		.i_video_ary     (video_ary),
		.i_vid_hs        (vid_hs),
		.i_vid_vs        (vid_vs),
		.i_pol_en        (pol_en),
		.i_pol_len       (HS_LOW),
		.i_cs_en         (cs_en),
		.i_hs_inv        (HS_HIGH > HS_LOW),
		.i_io_dout       (io_dout),
		.i_led           (led),
		.i_vol_att       (vol_att),
		.i_window        (window),
		.i_vga_hs        (vga_hs),
		.i_vga_vs        (vga_vs),
		.i_csync         (csync),
		.o_val_errs      (val_errs),
		.o_other_errs    (other_errs)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	task automatic draw(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	// Inputs change 2 units after the edge
	task automatic tick(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#2;
		end
	endtask

	task automatic send_word(input scaler_ctrl_pkg::io_word_t word);
		host.din = word;
		host.uio = 1'b1;
		tick(1);
		host.io_clk = 1'b1;
		while (io_ack !== 1'b1) begin
			tick(1);
		end
		host.io_clk = 1'b0;
		while (io_ack !== 1'b0) begin
			tick(1);
		end
	endtask

	task automatic start_cmd(input scaler_ctrl_pkg::cmd_t cmd);
		send_word({8'h00, cmd});
	endtask

	task automatic end_cmd();
		host.uio = 1'b0;
		tick(4);
	endtask

	task automatic request_check(input int idx);
		chk_req[idx] = 1'b1;
		tick(1);
		chk_req[idx] = 1'b0;
	endtask

	task automatic random_config();
		logic [31:0] r;
		logic [31:0] sel;
		draw(10, r);
		stim_cfg.width = 12'd640 + r[11:0];
		draw(10, r);
		stim_cfg.height = 12'd360 + r[11:0];
		draw(2, sel);
		draw(11, r);
		stim_cfg.vset = (sel[1:0] == 2'd0) ? 12'd0 : r[11:0];
		draw(2, sel);
		draw(11, r);
		stim_cfg.hset = (sel[1:0] == 2'd0) ? 12'd0 : r[11:0];
		draw(3, r);
		stim_cfg.freescale = (r[2:0] == 3'd0);
		draw(6, r);
		stim_cfg.arc1x = 13'd1 + r[12:0];
		draw(6, r);
		stim_cfg.arc1y = 13'd1 + r[12:0];
		// Second custom pair is sometimes a direct size
		draw(1, sel);
		draw(11, r);
		stim_cfg.arc2x = {sel[0], 12'd1 + r[11:0]};
		draw(11, r);
		stim_cfg.arc2y = {1'b0, 12'd1 + r[11:0]};
		draw(2, sel);
		draw(8, r);
		video_arx = 13'd1 + r[12:0];
		draw(8, r);
		video_ary = 13'd1 + r[12:0];
		if (sel[1:0] != 2'd0) begin
			// Custom pair 1 or 2, or no aspect at all
			video_arx = (sel[1:0] == 2'd3) ? 13'd0 : {11'd0, sel[1:0]};
			video_ary = '0;
		end
	endtask

	task automatic write_config();
		start_cmd(scaler_ctrl_pkg::CMD_TIMING);
		request_check(CHK_RD_TIMING);
		send_word({4'h0, stim_cfg.width});
		repeat (3) begin
			send_word(16'h0000);
		end
		send_word({4'h0, stim_cfg.height});
		end_cmd();
		start_cmd(scaler_ctrl_pkg::CMD_VSET);
		send_word({4'h0, stim_cfg.vset});
		end_cmd();
		start_cmd(scaler_ctrl_pkg::CMD_HSET);
		send_word({stim_cfg.freescale, 3'b000, stim_cfg.hset});
		end_cmd();
		start_cmd(scaler_ctrl_pkg::CMD_ARC);
		send_word({3'b000, stim_cfg.arc1x});
		send_word({3'b000, stim_cfg.arc1y});
		send_word({3'b000, stim_cfg.arc2x});
		send_word({3'b000, stim_cfg.arc2y});
		end_cmd();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Processes

	// Inverted hsync, long high phase
	initial begin
		vid_hs = 1'b1;
		forever begin
			tick(HS_HIGH);
			vid_hs = 1'b0;
			tick(HS_LOW);
			vid_hs = 1'b1;
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors: %0d wrong values, %0d other", val_errs, other_errs);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		logic [31:0] r;
		host      = '0;
		video_arx = '0;
		video_ary = '0;
		vid_vs    = 1'b0;
		resetd    = 1'b1;
		chk_req   = '0;
		led_word  = '0;
		vol_word  = '0;
		pol_en    = 1'b0;
		cs_en     = 1'b0;
		stim_cfg  = '0;
		lfsr      = 32'h91d79552;
		tick(10);
		resetd = 1'b0;
		tick(2);
		request_check(CHK_RESET);

		repeat (2) begin
			draw(16, r);
			led_word = r[15:0];
			draw(16, r);
			vol_word = r[15:0];
			start_cmd(scaler_ctrl_pkg::CMD_LED);
			send_word(led_word);
			end_cmd();
			start_cmd(scaler_ctrl_pkg::CMD_VOL);
			send_word(vol_word);
			end_cmd();
			request_check(CHK_REGS);
		end

		// Polarity settles within two periods
		tick(2 * HS_PERIOD);
		pol_en = 1'b1;
		tick(HS_PERIOD);
		// One vsync pulse, high phase shorter than low
		vid_vs = 1'b1;
		tick(VS_LEN);
		vid_vs = 1'b0;
		tick(3 * HS_PERIOD - VS_LEN);
		pol_en = 1'b0;

		for (int i = 0; i < N_WIN; i++) begin
			random_config();
			write_config();
			tick(WIN_WAIT);
			request_check(CHK_WINDOW);
			start_cmd(scaler_ctrl_pkg::CMD_READ_AR);
			send_word(16'h0000);
			request_check(CHK_RD_ARX);
			send_word(16'h0000);
			request_check(CHK_RD_ARY);
			end_cmd();
		end

		// Composite sync on the hsync pin
		start_cmd(scaler_ctrl_pkg::CMD_CFG);
		send_word(16'h0008);
		end_cmd();
		tick(8);
		cs_en = 1'b1;
		tick(4 * HS_PERIOD);
		cs_en = 1'b0;
		tick(2);

		$display("Errors: %0d wrong values, %0d other", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* flist.f */
verilog/scaler_ctrl_pkg.sv
verilog/ar_muldiv.sv
verilog/hps_cmd_decoder.sv
verilog/video_window_calc.sv
verilog/sync_polarity_fix.sv
verilog/csync_gen.sv
verilog/scaler_ctrl_top.sv
sim/tb_checker.sv
sim/tb_scaler_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
verilator --binary --timing -Wno-fatal --top-module tb_scaler_ctrl -f flist.f -o tb_scaler_ctrl \
	&& ./obj_dir/tb_scaler_ctrl | tee /dev/stderr | grep "TEST PASS" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
